// File: design/edpPkg.sv
`default_nettype none

package edpPkg;

  // Data word and adder widths, bit 0 is the most significant
  localparam int wordWidth = 36;
  localparam int halfWidth = wordWidth / 2;
  localparam int adWidth = 38;
  localparam int fmAdrWidth = 4;

  // ADA operand source
  typedef enum logic [1:0] {
    adaAr,
    adaArx,
    adaMq,
    adaPc
  } adaSelT;

  // ADB operand source, two of them pre-shifted
  typedef enum logic [1:0] {
    adbFm,
    adbBrX2,
    adbBr,
    adbArX4
  } adbSelT;

  // AD function
  typedef enum logic [2:0] {
    adAdd,
    adSub,
    adAnd,
    adOr,
    adXor,
    adPassA,
    adPassB,
    adNotA
  } adOpT;

  typedef enum logic [1:0] {
    arZero,
    arCache,
    arAd,
    arShift
  } arSelT;

  typedef enum logic [1:0] {
    arxZero,
    arxCache,
    arxAd,
    arxMq
  } arxSelT;

  // MQ shift register function
  typedef enum logic [1:0] {
    mqHold,
    mqLoad,
    mqShl,
    mqShr
  } mqOpT;

  // Diagnostic readout source, code 7 unused
  typedef enum logic [2:0] {
    diagAr,
    diagArx,
    diagBr,
    diagBrx,
    diagMq,
    diagFm,
    diagAd
  } diagSelT;

endpackage

`default_nettype wire

// File: design/fastMem.sv
`default_nettype none

module fastMem
  import edpPkg::*;
(
  input  wire logic                  eboxClk,
  input  wire logic                  step,
  input  wire logic [fmAdrWidth-1:0] fmAdr,
  input  wire logic                  fmWriteL,
  input  wire logic                  fmWriteR,
  input  wire logic [0:wordWidth-1]  ar,
  output logic      [0:wordWidth-1]  fm
);

  localparam int fmDepth = 1 << fmAdrWidth;

  // Accumulator storage, contents undefined until written
  logic [0:wordWidth-1] mem [fmDepth];

  // Halves written independently from the old AR
  always_ff @(posedge eboxClk) begin
    if (step) begin
      if (fmWriteL) begin
        mem[fmAdr][0:halfWidth-1] <= ar[0:halfWidth-1];
      end
      if (fmWriteR) begin
        mem[fmAdr][halfWidth:wordWidth-1] <= ar[halfWidth:wordWidth-1];
      end
    end
  end

  // Combinational read feeds ADB and the readout in the same cycle
  always_comb begin
    fm = mem[fmAdr];
  end

endmodule

`default_nettype wire

// File: design/adderUnit.sv
`default_nettype none

module adderUnit
  import edpPkg::*;
(
  input  wire adaSelT                             adaSel,
  input  wire adbSelT                             adbSel,
  input  wire adOpT                               adOp,
  input  wire logic                               cry36,
  input  wire logic [0:wordWidth-1]               ar,
  input  wire logic [0:wordWidth-1]               arx,
  input  wire logic [0:wordWidth-1]               br,
  input  wire logic [0:wordWidth-1]               brx,
  input  wire logic [0:wordWidth-1]               mq,
  input  wire logic [0:wordWidth-1]               fm,
  input  wire logic [0:wordWidth-1]               pc,
  output logic      [wordWidth-adWidth:wordWidth-1] ad,
  output logic                                    adCarryOut,
  output logic                                    adOverflow
);

  logic [0:wordWidth-1] ada;
  logic [wordWidth-adWidth:wordWidth-1] adaExt;
  logic [wordWidth-adWidth:wordWidth-1] adbExt;
  // Bit 0 holds the carry out of the upper extension bit
  logic [0:adWidth] sum;
  logic isArith;

  // ADA mux
  always_comb begin
    unique case (adaSel)
      adaAr:  ada = ar;
      adaArx: ada = arx;
      adaMq:  ada = mq;
      adaPc:  ada = pc;
    endcase
  end

  // Two sign-extension copies on top of ADA
  assign adaExt = {{2{ada[0]}}, ada};

  // ADB mux with its extension bits
  always_comb begin
    unique case (adbSel)
      adbFm:   adbExt = {{2{fm[0]}}, fm};
      // Doubled, so the extension follows the new top bit
      adbBrX2: adbExt = {{2{br[1]}}, br[1:wordWidth-1], brx[0]};
      adbBr:   adbExt = {{2{br[0]}}, br};
      // Quadrupled, bits shifted out of AR become the extension
      adbArX4: adbExt = {ar[0], ar[1], ar[2:wordWidth-1], arx[0:1]};
    endcase
  end

  // AD function over all 38 bits
  always_comb begin
    unique case (adOp)
      adAdd:   sum = {1'b0, adaExt} + {1'b0, adbExt} + cry36;
      // Subtract ignores cry36, the +1 completes the two's complement
      adSub:   sum = {1'b0, adaExt} + {1'b0, ~adbExt} + 1'b1;
      adAnd:   sum = {1'b0, adaExt & adbExt};
      adOr:    sum = {1'b0, adaExt | adbExt};
      adXor:   sum = {1'b0, adaExt ^ adbExt};
      adPassA: sum = {1'b0, adaExt};
      adPassB: sum = {1'b0, adbExt};
      adNotA:  sum = {1'b0, ~adaExt};
    endcase
  end

  assign isArith = (adOp == adAdd) || (adOp == adSub);

  assign ad = sum[1:adWidth];

  // Logic ops and passes produce no carry
  assign adCarryOut = sum[0];

  // Sign of the word disagrees with the extension next to it
  assign adOverflow = isArith && (ad[0] != ad[-1]);

endmodule

`default_nettype wire

// File: design/arithRegs.sv
`default_nettype none

module arithRegs
  import edpPkg::*;
(
  input  wire logic                                 eboxClk,
  input  wire logic                                 rstN,
  input  wire logic                                 step,
  input  wire arSelT                                arSel,
  input  wire logic                                 arLoadL,
  input  wire logic                                 arLoadR,
  input  wire arxSelT                               arxSel,
  input  wire logic                                 arxLoad,
  input  wire logic                                 brLoad,
  input  wire logic                                 brxLoad,
  input  wire mqOpT                                 mqOp,
  input  wire logic [0:wordWidth-1]                 cacheData,
  input  wire logic [0:wordWidth-1]                 shData,
  input  wire logic [wordWidth-adWidth:wordWidth-1] ad,
  input  wire logic                                 adCarryOut,
  output logic      [0:wordWidth-1]                 ar,
  output logic      [0:wordWidth-1]                 arx,
  output logic      [0:wordWidth-1]                 br,
  output logic      [0:wordWidth-1]                 brx,
  output logic      [0:wordWidth-1]                 mq
);

  logic [0:wordWidth-1] arSrc;
  logic [0:wordWidth-1] arxSrc;
  logic [0:wordWidth-1] mqNext;

  // AR source, arZero clears whichever halves load
  always_comb begin
    unique case (arSel)
      arZero:  arSrc = '0;
      arCache: arSrc = cacheData;
      arAd:    arSrc = ad[0:wordWidth-1];
      arShift: arSrc = shData;
    endcase
  end

  // ARX source
  always_comb begin
    unique case (arxSel)
      arxZero:  arxSrc = '0;
      arxCache: arxSrc = cacheData;
      arxAd:    arxSrc = ad[0:wordWidth-1];
      arxMq:    arxSrc = mq;
    endcase
  end

  // MQ as a small universal shift register
  always_comb begin
    unique case (mqOp)
      mqHold: mqNext = mq;
      mqLoad: mqNext = ad[0:wordWidth-1];
      // Carry out of AD enters at the low end
      mqShl:  mqNext = {mq[1:wordWidth-1], adCarryOut};
      mqShr:  mqNext = {mq[0], mq[0:wordWidth-2]};
    endcase
  end

  // AR, loaded by halves
  always_ff @(posedge eboxClk or negedge rstN) begin
    if (!rstN) begin
      ar <= '0;
    end else if (step) begin
      if (arLoadL) begin
        ar[0:halfWidth-1] <= arSrc[0:halfWidth-1];
      end
      if (arLoadR) begin
        ar[halfWidth:wordWidth-1] <= arSrc[halfWidth:wordWidth-1];
      end
    end
  end

  always_ff @(posedge eboxClk or negedge rstN) begin
    if (!rstN) begin
      arx <= '0;
    end else if (step && arxLoad) begin
      arx <= arxSrc;
    end
  end

  // BR and BRX take the old AR and ARX
  always_ff @(posedge eboxClk or negedge rstN) begin
    if (!rstN) begin
      br <= '0;
      brx <= '0;
    end else if (step) begin
      if (brLoad) begin
        br <= ar;
      end
      if (brxLoad) begin
        brx <= arx;
      end
    end
  end

  always_ff @(posedge eboxClk or negedge rstN) begin
    if (!rstN) begin
      mq <= '0;
    end else if (step) begin
      mq <= mqNext;
    end
  end

endmodule

`default_nettype wire

// File: design/diagReadout.sv
`default_nettype none

module diagReadout
  import edpPkg::*;
(
  input  wire logic                                 eboxClk,
  input  wire logic                                 rstN,
  input  wire logic                                 diagReq,
  input  wire diagSelT                              diagSel,
  input  wire logic [0:wordWidth-1]                 ar,
  input  wire logic [0:wordWidth-1]                 arx,
  input  wire logic [0:wordWidth-1]                 br,
  input  wire logic [0:wordWidth-1]                 brx,
  input  wire logic [0:wordWidth-1]                 mq,
  input  wire logic [0:wordWidth-1]                 fm,
  input  wire logic [wordWidth-adWidth:wordWidth-1] ad,
  output logic      [0:wordWidth-1]                 ebusData,
  output logic                                      ebusDriving
);

  logic [0:wordWidth-1] selWord;

  always_comb begin
    case (diagSel)
      diagAr:  selWord = ar;
      diagArx: selWord = arx;
      diagBr:  selWord = br;
      diagBrx: selWord = brx;
      diagMq:  selWord = mq;
      diagFm:  selWord = fm;
      // Extension bits are not visible on the bus
      diagAd:  selWord = ad[0:wordWidth-1];
      default: selWord = '0;
    endcase
  end

  // Bus idles at zero between requests
  always_ff @(posedge eboxClk or negedge rstN) begin
    if (!rstN) begin
      ebusData <= '0;
      ebusDriving <= 1'b0;
    end else begin
      ebusData <= diagReq ? selWord : '0;
      ebusDriving <= diagReq;
    end
  end

endmodule

`default_nettype wire

// File: design/edpTop.sv
`default_nettype none

module edpTop
  import edpPkg::*;
(
  input  wire logic                                 eboxClk,
  input  wire logic                                 rstN,
  input  wire logic                                 step,
  input  wire adaSelT                               adaSel,
  input  wire adbSelT                               adbSel,
  input  wire adOpT                                 adOp,
  input  wire logic                                 cry36,
  input  wire arSelT                                arSel,
  input  wire logic                                 arLoadL,
  input  wire logic                                 arLoadR,
  input  wire arxSelT                               arxSel,
  input  wire logic                                 arxLoad,
  input  wire logic                                 brLoad,
  input  wire logic                                 brxLoad,
  input  wire mqOpT                                 mqOp,
  input  wire logic [fmAdrWidth-1:0]                fmAdr,
  input  wire logic                                 fmWriteL,
  input  wire logic                                 fmWriteR,
  input  wire logic [0:wordWidth-1]                 cacheData,
  input  wire logic [0:wordWidth-1]                 shData,
  input  wire logic [0:wordWidth-1]                 pc,
  input  wire logic                                 diagReq,
  input  wire diagSelT                              diagSel,
  output logic      [wordWidth-adWidth:wordWidth-1] ad,
  output logic                                      adCarryOut,
  output logic                                      adOverflow,
  output logic      [0:wordWidth-1]                 ar,
  output logic      [0:wordWidth-1]                 arx,
  output logic      [0:wordWidth-1]                 br,
  output logic      [0:wordWidth-1]                 brx,
  output logic      [0:wordWidth-1]                 mq,
  output logic      [0:wordWidth-1]                 ebusData,
  output logic                                      ebusDriving
);

  logic [0:wordWidth-1] fm;

  // Accumulators beside the adder
  fastMem uFastMem (
    .eboxClk  (eboxClk),
    .step     (step),
    .fmAdr    (fmAdr),
    .fmWriteL (fmWriteL),
    .fmWriteR (fmWriteR),
    .ar       (ar),
    .fm       (fm)
  );

  adderUnit uAdderUnit (
    .adaSel     (adaSel),
    .adbSel     (adbSel),
    .adOp       (adOp),
    .cry36      (cry36),
    .ar         (ar),
    .arx        (arx),
    .br         (br),
    .brx        (brx),
    .mq         (mq),
    .fm         (fm),
    .pc         (pc),
    .ad         (ad),
    .adCarryOut (adCarryOut),
    .adOverflow (adOverflow)
  );

  arithRegs uArithRegs (
    .eboxClk    (eboxClk),
    .rstN       (rstN),
    .step       (step),
    .arSel      (arSel),
    .arLoadL    (arLoadL),
    .arLoadR    (arLoadR),
    .arxSel     (arxSel),
    .arxLoad    (arxLoad),
    .brLoad     (brLoad),
    .brxLoad    (brxLoad),
    .mqOp       (mqOp),
    .cacheData  (cacheData),
    .shData     (shData),
    .ad         (ad),
    .adCarryOut (adCarryOut),
    .ar         (ar),
    .arx        (arx),
    .br         (br),
    .brx        (brx),
    .mq         (mq)
  );

  diagReadout uDiagReadout (
    .eboxClk     (eboxClk),
    .rstN        (rstN),
    .diagReq     (diagReq),
    .diagSel     (diagSel),
    .ar          (ar),
    .arx         (arx),
    .br          (br),
    .brx         (brx),
    .mq          (mq),
    .fm          (fm),
    .ad          (ad),
    .ebusData    (ebusData),
    .ebusDriving (ebusDriving)
  );

endmodule

`default_nettype wire

// File: verification/edpTop_props.sv
`default_nettype none

module edpTop_props
  import edpPkg::*;
(
  input wire logic                                 eboxClk,
  input wire logic                                 rstN,
  input wire logic                                 step,
  input wire logic                                 diagReq,
  input wire logic [wordWidth-adWidth:wordWidth-1] ad,
  input wire logic [0:wordWidth-1]                 ar,
  input wire logic [0:wordWidth-1]                 arx,
  input wire logic [0:wordWidth-1]                 br,
  input wire logic [0:wordWidth-1]                 brx,
  input wire logic [0:wordWidth-1]                 mq,
  input wire logic [0:wordWidth-1]                 ebusData,
  input wire logic                                 ebusDriving
);

  timeunit 1ns;
  timeprecision 100ps;

  // Bus driven only right after a request
  drivingAfterReq: assert property (@(posedge eboxClk) disable iff (!rstN)
    ebusDriving |-> $past(diagReq))
    else $error("ebusDriving high without a request in the previous cycle");

  idleBusZero: assert property (@(posedge eboxClk) disable iff (!rstN)
    !ebusDriving |-> (ebusData == '0))
    else $error("ebusData nonzero while the bus is not driven");

  adKnown: assert property (@(posedge eboxClk) disable iff (!rstN)
    !$isunknown(ad))
    else $error("ad has unknown bits");

  // No microinstruction, no register change
  regsHold: assert property (@(posedge eboxClk) disable iff (!rstN)
    !$past(step) |-> ($stable(ar) && $stable(arx) && $stable(br)
                      && $stable(brx) && $stable(mq)))
    else $error("a register changed in a cycle without step");

endmodule

`default_nettype wire

// File: verification/edpTb.sv
`default_nettype none

module edpTb
  import edpPkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int resetCycles = 10;
  localparam int sweepCycles = 2 * 128;
  localparam int randCycles = 400;
  localparam int plannedCycles = resetCycles + sweepCycles + randCycles + 3;

  logic eboxClk;
  logic rstN;
  logic step;
  adaSelT adaSel;
  adbSelT adbSel;
  adOpT adOp;
  logic cry36;
  arSelT arSel;
  logic arLoadL, arLoadR;
  arxSelT arxSel;
  logic arxLoad, brLoad, brxLoad;
  mqOpT mqOp;
  logic [fmAdrWidth-1:0] fmAdr;
  logic fmWriteL, fmWriteR;
  logic [0:wordWidth-1] cacheData, shData, pc;
  logic diagReq;
  diagSelT diagSel;
  logic [wordWidth-adWidth:wordWidth-1] ad;
  logic adCarryOut, adOverflow;
  logic [0:wordWidth-1] ar, arx, br, brx, mq;
  logic [0:wordWidth-1] ebusData;
  logic ebusDriving;

  // Reference copies of the data path state
  logic [0:wordWidth-1] mAr, mArx, mBr, mBrx, mMq, expEbusData;
  logic expEbusDriving;
  logic [0:wordWidth-1] mFm [16];
  // Bit 1 marks the left half and bit 0 the right half
  logic [1:0] mFmValid [16];

  edpTop DUT (.*);

  bind edpTop edpTop_props props (.*);

  initial begin
    eboxClk = 1'b0;
    forever #5 eboxClk = ~eboxClk;
  end

  initial begin
    #(plannedCycles * 10 + 100);
    $display("Regression failed");
    $fatal(1, "Timeout: the run did not finish within the planned number of cycles");
  end

  function automatic logic [0:wordWidth-1] randWord();
    logic [63:0] r;
    r = {$urandom(), $urandom()};
    return r[wordWidth-1:0];
  endfunction

  function automatic logic coinFlip();
    logic [31:0] r;
    r = $urandom();
    return r[0];
  endfunction

  function automatic logic [adWidth-1:0] adaModel();
    logic [0:wordWidth-1] w;
    case (adaSel)
      adaAr: w = mAr;
      adaArx: w = mArx;
      adaMq: w = mMq;
      default: w = pc;
    endcase
    return {{2{w[0]}}, w};
  endfunction

  function automatic logic [adWidth-1:0] adbModel();
    logic [71:0] pair;
    logic [0:wordWidth-1] w;
    w = mFm[fmAdr];
    case (adbSel)
      adbFm: return {{2{w[0]}}, w};
      adbBrX2: begin
        pair = {mBr, mBrx};
        return {{2{pair[70]}}, pair[70:35]};
      end
      adbBr: return {{2{mBr[0]}}, mBr};
      default: begin
        // Top 38 bits of AR,ARX after two left shifts
        pair = {mAr, mArx};
        return pair[71:34];
      end
    endcase
  endfunction

  // Carry out sits above the 38-bit result
  function automatic logic [adWidth:0] adModel(input logic [adWidth-1:0] a,
                                                input logic [adWidth-1:0] b);
    case (adOp)
      adAdd: return {1'b0, a} + {1'b0, b} + {{adWidth{1'b0}}, cry36};
      // Carry set when no borrow
      adSub: return {a >= b, a - b};
      adAnd: return {1'b0, a & b};
      adOr: return {1'b0, a | b};
      adXor: return {1'b0, a ^ b};
      adPassA: return {1'b0, a};
      adPassB: return {1'b0, b};
      default: return {1'b0, ~a};
    endcase
  endfunction

  task automatic reportMismatch(input string name, input string got, input string exp);
    $display("Fail at %0d ns: %s is %s, expected %s", $time, name, got, exp);
    $display("Regression failed");
    $fatal(1, "Mismatch on %s", name);
  endtask

  task automatic checkWord(input string name, input logic [0:wordWidth-1] got,
                           input logic [0:wordWidth-1] exp);
    if (got !== exp) begin
      reportMismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
    end
  endtask

  task automatic checkAd(input string name, input logic [wordWidth-adWidth:wordWidth-1] got,
                         input logic [wordWidth-adWidth:wordWidth-1] exp);
    if (got !== exp) begin
      reportMismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      reportMismatch(name, $sformatf("%b", got), $sformatf("%b", exp));
    end
  endtask

  task automatic idleInputs();
    step = 1'b0;
    adaSel = adaAr;
    adbSel = adbBr;
    adOp = adAdd;
    cry36 = 1'b0;
    arSel = arZero;
    arLoadL = 1'b0;
    arLoadR = 1'b0;
    arxSel = arxZero;
    arxLoad = 1'b0;
    brLoad = 1'b0;
    brxLoad = 1'b0;
    mqOp = mqHold;
    fmAdr = '0;
    fmWriteL = 1'b0;
    fmWriteR = 1'b0;
    cacheData = '0;
    shData = '0;
    pc = '0;
    diagReq = 1'b0;
    diagSel = diagAr;
  endtask

  task automatic randomInputs();
    step = ($urandom_range(0, 3) != 0);
    adaSel = adaSelT'($urandom_range(0, 3));
    adbSel = adbSelT'($urandom_range(0, 3));
    adOp = adOpT'($urandom_range(0, 7));
    cry36 = coinFlip();
    arSel = arSelT'($urandom_range(0, 3));
    arLoadL = coinFlip();
    arLoadR = coinFlip();
    arxSel = arxSelT'($urandom_range(0, 3));
    arxLoad = coinFlip();
    brLoad = coinFlip();
    brxLoad = coinFlip();
    mqOp = mqOpT'($urandom_range(0, 3));
    fmAdr = fmAdrWidth'($urandom_range(0, 15));
    fmWriteL = coinFlip();
    fmWriteR = coinFlip();
    cacheData = randWord();
    shData = randWord();
    pc = randWord();
    diagReq = coinFlip();
    diagSel = diagSelT'($urandom_range(0, 6));
    // Keep unwritten accumulators away from AD and the bus
    if (mFmValid[fmAdr] != 2'b11 && adbSel == adbFm) begin
      adbSel = adbBr;
    end
    if (mFmValid[fmAdr] != 2'b11 && diagSel == diagFm) begin
      diagSel = diagMq;
    end
  endtask

  // Check mid-cycle and advance the model across the next edge
  task automatic runCycle();
    logic [adWidth:0] res;
    logic [0:wordWidth-1] arSrc;
    logic [0:wordWidth-1] nAr;
    logic [0:wordWidth-1] nArx;
    logic [0:wordWidth-1] nMq;
    logic [0:wordWidth-1] diagWord;
    #4;
    res = adModel(adaModel(), adbModel());
    checkAd("ad", ad, res[adWidth-1:0]);
    checkBit("adCarryOut", adCarryOut, res[adWidth]);
    checkBit("adOverflow", adOverflow,
             (adOp inside {adAdd, adSub}) && (res[wordWidth-1] != res[wordWidth]));
    checkWord("ar", ar, mAr);
    checkWord("arx", arx, mArx);
    checkWord("br", br, mBr);
    checkWord("brx", brx, mBrx);
    checkWord("mq", mq, mMq);
    checkWord("ebusData", ebusData, expEbusData);
    checkBit("ebusDriving", ebusDriving, expEbusDriving);
    case (arSel)
      arZero: arSrc = '0;
      arCache: arSrc = cacheData;
      arAd: arSrc = res[wordWidth-1:0];
      default: arSrc = shData;
    endcase
    nAr = mAr;
    if (arLoadL) begin
      nAr[0:halfWidth-1] = arSrc[0:halfWidth-1];
    end
    if (arLoadR) begin
      nAr[halfWidth:wordWidth-1] = arSrc[halfWidth:wordWidth-1];
    end
    case (arxSel)
      arxZero: nArx = '0;
      arxCache: nArx = cacheData;
      arxAd: nArx = res[wordWidth-1:0];
      default: nArx = mMq;
    endcase
    case (mqOp)
      mqHold: nMq = mMq;
      mqLoad: nMq = res[wordWidth-1:0];
      mqShl: nMq = {mMq[1:wordWidth-1], res[adWidth]};
      default: nMq = {mMq[0], mMq[0:wordWidth-2]};
    endcase
    case (diagSel)
      diagAr: diagWord = mAr;
      diagArx: diagWord = mArx;
      diagBr: diagWord = mBr;
      diagBrx: diagWord = mBrx;
      diagMq: diagWord = mMq;
      diagFm: diagWord = mFm[fmAdr];
      diagAd: diagWord = res[wordWidth-1:0];
      default: diagWord = '0;
    endcase
    @(posedge eboxClk);
    #1;
    expEbusData = diagReq ? diagWord : '0;
    expEbusDriving = diagReq;
    if (step) begin
      if (fmWriteL) begin
        mFm[fmAdr][0:halfWidth-1] = mAr[0:halfWidth-1];
        mFmValid[fmAdr][1] = 1'b1;
      end
      if (fmWriteR) begin
        mFm[fmAdr][halfWidth:wordWidth-1] = mAr[halfWidth:wordWidth-1];
        mFmValid[fmAdr][0] = 1'b1;
      end
      if (brLoad) begin
        mBr = mAr;
      end
      if (brxLoad) begin
        mBrx = mArx;
      end
      if (arxLoad) begin
        mArx = nArx;
      end
      mAr = nAr;
      mMq = nMq;
    end
  endtask

  initial begin
    void'($urandom(32'he383_fe07));
    rstN = 1'b0;
    idleInputs();
    {mAr, mArx, mBr, mBrx, mMq, expEbusData} = '0;
    expEbusDriving = 1'b0;
    for (int i = 0; i < 16; i++) begin
      mFmValid[i] = 2'b00;
    end
    repeat (resetCycles) @(posedge eboxClk);
    #1;
    rstN = 1'b1;
    // Straight out of reset everything reads zero
    runCycle();
    // Load fresh operands and step through one AD combination per pass
    for (int combo = 0; combo < 128; combo++) begin
      randomInputs();
      step = 1'b1;
      arSel = arCache;
      arLoadL = 1'b1;
      arLoadR = 1'b1;
      arxSel = arxCache;
      arxLoad = 1'b1;
      brLoad = 1'b1;
      brxLoad = 1'b1;
      mqOp = mqLoad;
      adbSel = adbBr;
      diagReq = 1'b0;
      fmAdr = combo[3:0];
      fmWriteL = 1'b1;
      fmWriteR = 1'b1;
      runCycle();
      randomInputs();
      step = 1'b0;
      fmAdr = combo[3:0];
      adOp = adOpT'(combo[6:4]);
      adaSel = adaSelT'(combo[3:2]);
      adbSel = adbSelT'(combo[1:0]);
      runCycle();
    end
    repeat (randCycles) begin
      randomInputs();
      runCycle();
    end
    // Bus must drop once requests stop
    idleInputs();
    runCycle();
    runCycle();
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
design/edpPkg.sv
design/fastMem.sv
design/adderUnit.sv
design/arithRegs.sv
design/diagReadout.sv
design/edpTop.sv
verification/edpTop_props.sv
verification/edpTb.sv

// File: Makefile
TOP := edpTb
SIM := obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

$(SIM): flist.f $(wildcard design/*.sv verification/*.sv)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f flist.f

test: $(SIM)
	./$(SIM) > sim.log 2>&1 || echo "Regression failed" >> sim.log
	@cat sim.log
	@if grep -q "Regression failed" sim.log; then echo "Simulation reported failure"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
